// ==== Makefile ====
SIM      := verilator
TOP      := tb_scope_acquisition
FILELIST := src.f
FLAGS    := --binary --timing --assert
BUILD    := obj_dir
LOG      := sim.log
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^TESTS PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== include/scope_consts.svh ====
// sizing macros for the scope acquisition path, included by the packages and sized modules
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// width of one adc code, also used for the trigger level
`define SCOPE_SAMPLE_W 12

// samples kept per triggered record
`define SCOPE_RECORD_LEN 256

// number of parallel segment statistics units
`define SCOPE_NUM_SEGMENTS 4

// samples covered by each segment unit
`define SCOPE_SEGMENT_LEN (`SCOPE_RECORD_LEN / `SCOPE_NUM_SEGMENTS)

// width of the time base decimation setting
`define SCOPE_PACE_W 12

`endif

// ==== source/capture_buffer.sv ====
// record memory, written by the capture unit and read back by the display line fetch
`include "scope_consts.svh"

module capture_buffer (
   input  logic                           clk,
   input  logic                           wr_en,
   input  scope_sample_pkg::record_addr_t wr_addr,
   input  scope_sample_pkg::sample_t      wr_data,
   input  scope_sample_pkg::record_addr_t rd_addr,
   output scope_sample_pkg::sample_t      rd_data
);

   import scope_sample_pkg::*;

   // one entry per record sample, maps onto a block ram
   sample_t mem [`SCOPE_RECORD_LEN];

   // write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read port, data one cycle after the address
   // contents only stable while no capture runs
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== source/sample_pacer.sv ====
// time base decimator that keeps every pace-th valid adc sample and hands it to the trigger as a tick
module sample_pacer (
   input  logic                      clk,
   input  logic                      rst,
   input  scope_sample_pkg::sample_t adc_data,
   input  logic                      adc_valid,
   input  scope_ctrl_pkg::pace_count_t pace,
   input  logic                      restart,
   output logic                      tick,
   output scope_sample_pkg::sample_t tick_data
);

   import scope_ctrl_pkg::*;

   // position inside the current pace window
   pace_count_t count;
   // last count value before wrapping
   pace_count_t count_last;

   // pace of 0 acts as 1, so the window never goes negative
   assign count_last = (pace == '0) ? '0 : pace_count_t'(pace - 1'b1);

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
         tick  <= 1'b0;
      end else if (restart) begin
         // new capture starts on the very next valid
         count <= '0;
         tick  <= 1'b0;
      end else begin
         // first valid of each window is the kept one
         tick <= adc_valid && (count == '0);
         if (adc_valid) begin
            if (count >= count_last) begin
               count <= '0;
            end else begin
               count <= count + 1'b1;
            end
         end
      end
   end

   // sample follows every valid and only matters with tick
   always_ff @(posedge clk) begin
      if (adc_valid) begin
         tick_data <= adc_data;
      end
   end

   // a steady pace above one never keeps two samples back to back
   a_tick_spacing : assert property (@(posedge clk) disable iff (rst)
      (tick && (pace > pace_count_t'(1)) && $stable(pace)) |=> !tick);

endmodule

// ==== source/scope_acquisition.sv ====
// acquisition top, adc samples in, triggered record and its measurements out to the display
`include "scope_consts.svh"

module scope_acquisition (
   input  logic                           clk,
   input  logic                           rst,
   input  scope_sample_pkg::sample_t      adc_data,
   input  logic                           adc_valid,
   input  scope_ctrl_pkg::pace_count_t    pace,
   input  scope_sample_pkg::sample_t      trigger_level,
   input  logic                           arm,
   output logic                           busy,
   output logic                           record_done,
   input  scope_sample_pkg::record_addr_t rd_addr,
   output scope_sample_pkg::sample_t      rd_data,
   output logic                           meas_valid,
   output scope_sample_pkg::sample_t      meas_min,
   output scope_sample_pkg::sample_t      meas_max,
   output scope_sample_pkg::sample_t      meas_average
);

   import scope_sample_pkg::*;

   // pacer to trigger
   logic         tick;
   sample_t      tick_data;
   logic         pacer_restart;

   // record write bus, shared by buffer and segment units
   logic         wr_en;
   record_addr_t wr_addr;
   sample_t      wr_data;
   logic         seg_clear;

   // per segment results, indexed by segment
   sample_t  [`SCOPE_NUM_SEGMENTS-1:0] seg_min;
   sample_t  [`SCOPE_NUM_SEGMENTS-1:0] seg_max;
   seg_sum_t [`SCOPE_NUM_SEGMENTS-1:0] seg_sum;

   // arm during a running record must not shift the time base
   assign pacer_restart = arm && !busy;

   sample_pacer u_sample_pacer (
      .clk,
      .rst,
      .adc_data,
      .adc_valid,
      .pace,
      .restart   (pacer_restart),
      .tick,
      .tick_data
   );

   trigger_capture u_trigger_capture (
      .clk,
      .rst,
      .arm,
      .tick,
      .tick_data,
      .trigger_level,
      .wr_en,
      .wr_addr,
      .wr_data,
      .seg_clear,
      .record_done,
      .busy
   );

   capture_buffer u_capture_buffer (
      .clk,
      .wr_en,
      .wr_addr,
      .wr_data,
      .rd_addr,
      .rd_data
   );

   // one statistics unit per record quarter
   for (genvar g = 0; g < `SCOPE_NUM_SEGMENTS; g++) begin : g_seg
      segment_stats #(
         .SEG_INDEX (g)
      ) u_segment_stats (
         .clk,
         .rst,
         .clear   (seg_clear),
         .wr_en,
         .wr_addr,
         .wr_data,
         .seg_min (seg_min[g]),
         .seg_max (seg_max[g]),
         .seg_sum (seg_sum[g])
      );
   end

   stats_merge u_stats_merge (
      .clk,
      .rst,
      .record_done,
      .seg_min,
      .seg_max,
      .seg_sum,
      .meas_valid,
      .meas_min,
      .meas_max,
      .meas_average
   );

endmodule

// ==== source/scope_ctrl_pkg.sv ====
// control types of the acquisition path, the state machine encodings and the pace count
`include "scope_consts.svh"

package scope_ctrl_pkg;

   // decimation setting and pacer counter
   // zero behaves like one
   typedef logic [`SCOPE_PACE_W-1:0] pace_count_t;

   // trigger and capture sequencing
   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_ARMED,
      CAP_CAPTURE
   } capture_state_e;

   // walk over the segment results
   typedef enum logic [1:0] {
      MRG_IDLE,
      MRG_ACCUM,
      MRG_DONE
   } merge_state_e;

endpackage

// ==== source/scope_sample_pkg.sv ====
// data types of the acquisition path, imported by every block that carries samples or sums
`include "scope_consts.svh"

package scope_sample_pkg;

   // one adc code or a trigger level, unsigned
   typedef logic [`SCOPE_SAMPLE_W-1:0] sample_t;

   // index into the record
   // top bits pick the segment unit
   typedef logic [$clog2(`SCOPE_RECORD_LEN)-1:0] record_addr_t;

   // sum of one segment, wide enough for a full scale segment
   typedef logic [`SCOPE_SAMPLE_W+$clog2(`SCOPE_SEGMENT_LEN)-1:0] seg_sum_t;

   // sum of the whole record
   // the average is its top sample_t bits
   typedef logic [`SCOPE_SAMPLE_W+$clog2(`SCOPE_RECORD_LEN)-1:0] rec_sum_t;

endpackage

// ==== source/segment_stats.sv ====
// min, max and sum tracker for one quarter of the record, snooping the record write bus
`include "scope_consts.svh"

module segment_stats #(
   parameter int SEG_INDEX = 0
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           clear,
   input  logic                           wr_en,
   input  scope_sample_pkg::record_addr_t wr_addr,
   input  scope_sample_pkg::sample_t      wr_data,
   output scope_sample_pkg::sample_t      seg_min,
   output scope_sample_pkg::sample_t      seg_max,
   output scope_sample_pkg::seg_sum_t     seg_sum
);

   import scope_sample_pkg::*;

   localparam int ADDR_W = $bits(record_addr_t);
   localparam int SEL_W  = $clog2(`SCOPE_NUM_SEGMENTS);

   // write lands in this unit's quarter
   logic hit;

   assign hit = wr_en && (wr_addr[ADDR_W-1 -: SEL_W] == SEL_W'(SEG_INDEX));

   always_ff @(posedge clk) begin
      if (rst) begin
         seg_min <= '1;
         seg_max <= '0;
         seg_sum <= '0;
      end else if (clear) begin
         if (hit) begin
            // crossing sample seeds the first segment
            seg_min <= wr_data;
            seg_max <= wr_data;
            seg_sum <= seg_sum_t'(wr_data);
         end else begin
            seg_min <= '1;
            seg_max <= '0;
            seg_sum <= '0;
         end
      end else if (hit) begin
         if (wr_data < seg_min) begin
            seg_min <= wr_data;
         end
         if (wr_data > seg_max) begin
            seg_max <= wr_data;
         end
         seg_sum <= seg_sum + seg_sum_t'(wr_data);
      end
   end

   // clear comes only with the crossing write to the record start
   a_clear_on_start : assert property (@(posedge clk) disable iff (rst)
      clear |-> (wr_en && wr_addr == '0));

endmodule

// ==== source/stats_merge.sv ====
// folds the per segment results into the record min, max and average after each record
`include "scope_consts.svh"

module stats_merge (
   input  logic                                                  clk,
   input  logic                                                  rst,
   input  logic                                                  record_done,
   input  scope_sample_pkg::sample_t  [`SCOPE_NUM_SEGMENTS-1:0]  seg_min,
   input  scope_sample_pkg::sample_t  [`SCOPE_NUM_SEGMENTS-1:0]  seg_max,
   input  scope_sample_pkg::seg_sum_t [`SCOPE_NUM_SEGMENTS-1:0]  seg_sum,
   output logic                                                  meas_valid,
   output scope_sample_pkg::sample_t                             meas_min,
   output scope_sample_pkg::sample_t                             meas_max,
   output scope_sample_pkg::sample_t                             meas_average
);

   import scope_sample_pkg::*;
   import scope_ctrl_pkg::*;

   localparam int SEL_W     = $clog2(`SCOPE_NUM_SEGMENTS);
   localparam int AVG_SHIFT = $clog2(`SCOPE_RECORD_LEN);

   merge_state_e     state;
   // segment being folded
   logic [SEL_W-1:0] idx;
   sample_t          acc_min;
   sample_t          acc_max;
   rec_sum_t         acc_sum;

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= MRG_IDLE;
         idx          <= '0;
         acc_min      <= '1;
         acc_max      <= '0;
         acc_sum      <= '0;
         meas_valid   <= 1'b0;
         meas_min     <= '0;
         meas_max     <= '0;
         meas_average <= '0;
      end else begin
         meas_valid <= 1'b0;
         case (state)
            MRG_IDLE: begin
               if (record_done) begin
                  state   <= MRG_ACCUM;
                  idx     <= '0;
                  acc_min <= '1;
                  acc_max <= '0;
                  acc_sum <= '0;
               end
            end
            MRG_ACCUM: begin
               // one segment per cycle
               if (seg_min[idx] < acc_min) begin
                  acc_min <= seg_min[idx];
               end
               if (seg_max[idx] > acc_max) begin
                  acc_max <= seg_max[idx];
               end
               acc_sum <= acc_sum + rec_sum_t'(seg_sum[idx]);
               idx     <= idx + 1'b1;
               if (idx == SEL_W'(`SCOPE_NUM_SEGMENTS - 1)) begin
                  state <= MRG_DONE;
               end
            end
            MRG_DONE: begin
               // outputs hold until the next record
               meas_min     <= acc_min;
               meas_max     <= acc_max;
               meas_average <= sample_t'(acc_sum >> AVG_SHIFT);
               meas_valid   <= 1'b1;
               state        <= MRG_IDLE;
            end
            default: begin
               state <= MRG_IDLE;
            end
         endcase
      end
   end

   // one pulse per record
   a_single_pulse : assert property (@(posedge clk) disable iff (rst)
      meas_valid |=> !meas_valid);

endmodule

// ==== source/trigger_capture.sv ====
// rising edge trigger and record writer that frames each record with a clear pulse and a done pulse
`include "scope_consts.svh"

module trigger_capture (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          arm,
   input  logic                          tick,
   input  scope_sample_pkg::sample_t     tick_data,
   input  scope_sample_pkg::sample_t     trigger_level,
   output logic                          wr_en,
   output scope_sample_pkg::record_addr_t wr_addr,
   output scope_sample_pkg::sample_t     wr_data,
   output logic                          seg_clear,
   output logic                          record_done,
   output logic                          busy
);

   import scope_sample_pkg::*;
   import scope_ctrl_pkg::*;

   localparam record_addr_t LAST_ADDR = record_addr_t'(`SCOPE_RECORD_LEN - 1);

   capture_state_e state;
   // previous tick sample for the edge test
   sample_t        prev;
   // set once the first tick after arm has loaded prev
   logic           primed;
   // address of the next write while capturing
   record_addr_t   addr;
   // rising crossing seen on the current tick
   logic           crossing;
   logic           in_capture;

   assign crossing   = primed && (prev < trigger_level) && (tick_data >= trigger_level);
   assign in_capture = (state == CAP_CAPTURE);

   // crossing sample is written straight away at address 0
   assign seg_clear = tick && (state == CAP_ARMED) && crossing && !arm;
   assign wr_en     = (tick && in_capture) || seg_clear;
   assign wr_addr   = in_capture ? addr : '0;
   assign wr_data   = tick_data;

   // low again in the cycle record_done rises
   assign busy = (state != CAP_IDLE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= CAP_IDLE;
         primed      <= 1'b0;
         addr        <= '0;
         record_done <= 1'b0;
      end else begin
         record_done <= 1'b0;
         case (state)
            CAP_IDLE: begin
               // ticks here are dropped
               if (arm) begin
                  state  <= CAP_ARMED;
                  primed <= 1'b0;
               end
            end
            CAP_ARMED: begin
               if (arm) begin
                  // re-arm starts the priming over
                  primed <= 1'b0;
               end else if (tick) begin
                  primed <= 1'b1;
                  if (crossing) begin
                     state <= CAP_CAPTURE;
                     addr  <= record_addr_t'(1);
                  end
               end
            end
            CAP_CAPTURE: begin
               // arm is ignored until the record is complete
               if (tick) begin
                  addr <= addr + 1'b1;
                  if (addr == LAST_ADDR) begin
                     state       <= CAP_IDLE;
                     record_done <= 1'b1;
                  end
               end
            end
            default: begin
               state <= CAP_IDLE;
            end
         endcase
      end
   end

   // prev tracks every tick while waiting for the edge
   always_ff @(posedge clk) begin
      if (tick && (state == CAP_ARMED)) begin
         prev <= tick_data;
      end
   end

   // every write leaves the record still open or just closed
   a_write_in_record : assert property (@(posedge clk) disable iff (rst)
      wr_en |=> (in_capture || record_done));

endmodule

// ==== src.f ====
+incdir+include
source/scope_sample_pkg.sv
source/scope_ctrl_pkg.sv
source/sample_pacer.sv
source/trigger_capture.sv
source/capture_buffer.sv
source/segment_stats.sv
source/stats_merge.sv
source/scope_acquisition.sv
verification/tb_scope_acquisition.sv

// ==== verification/scope_trace.txt ====
# columns: pace level kind start step rearm chk exp_min exp_max exp_avg
# all numbers hex, kind is ramp, triangle or noise, chk 0 leaves the expected columns unused
1 3e8 ramp bb8 10 0 1 008 ff8 800
3 400 ramp 100 8 1 1 000 fe8 7f4
0 200 triangle 1770 20 0 1 00f ff0 7ff
1 800 noise 0 0 0 0 000 000 000
3 600 noise 0 0 1 0 000 000 000

// ==== verification/tb_scope_acquisition.sv ====
// trace driven testbench for the acquisition top that checks records and measurements against a model
`include "scope_consts.svh"

module tb_scope_acquisition;
   timeunit 1ns;
   timeprecision 100ps;

   import scope_sample_pkg::*;
   import scope_ctrl_pkg::*;

   localparam int REC_LEN       = `SCOPE_RECORD_LEN;
   localparam int MERGE_LATENCY = `SCOPE_NUM_SEGMENTS + 2;

   logic         clk = 1'b0;
   logic         rst;
   sample_t      adc_data;
   logic         adc_valid;
   pace_count_t  pace;
   sample_t      trigger_level;
   logic         arm;
   logic         busy;
   logic         record_done;
   record_addr_t rd_addr;
   sample_t      rd_data;
   logic         meas_valid;
   sample_t      meas_min;
   sample_t      meas_max;
   sample_t      meas_average;

   // one entry per trace line
   int t_pace[$], t_level[$], t_kind[$], t_start[$], t_step[$];
   int t_rearm[$], t_chk[$], t_min[$], t_max[$], t_avg[$];
   // expected record built by the model
   sample_t exp_rec [REC_LEN];
   int      seed = 38910;
   int      cycle_limit = 0;

   scope_acquisition u_dut (.*);

   always #20 clk = ~clk;

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("TESTS FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic compare_sample(input string name, input sample_t expected, input sample_t actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
         fail_run("sample value mismatch");
      end
   endtask

   task automatic compare_flag(input string name, input bit expected, input logic actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
         fail_run("control flag mismatch");
      end
   endtask

   // ramp wraps at full scale
   // triangle folds a 13 bit phase
   function automatic sample_t wave_value(input int kind, input int start, input int step,
                                          input int n);
      int phase;
      phase = start + step * n;
      if (kind == 1) begin
         phase = phase % 8192;
         if (phase < 4096) begin
            return sample_t'(phase);
         end
         return sample_t'(8191 - phase);
      end
      return sample_t'(phase % 4096);
   endfunction

   task automatic load_trace();
      int          fd;
      int          fields;
      int          p, lv, st, sp, re, ck, mn, mx, av;
      string       line;
      logic [63:0] kind_txt;
      fd = $fopen("verification/scope_trace.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open the trace file verification/scope_trace.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and column notes
            if (line.len() < 2 || line[0] == "#") begin
               continue;
            end
            fields = $sscanf(line, "%h %h %s %h %h %h %h %h %h %h",
                             p, lv, kind_txt, st, sp, re, ck, mn, mx, av);
            if (fields != 10) begin
               fail_run("a trace line does not have ten columns");
            end else if (kind_txt == 64'("ramp")) begin
               t_kind.push_back(0);
            end else if (kind_txt == 64'("triangle")) begin
               t_kind.push_back(1);
            end else if (kind_txt == 64'("noise")) begin
               t_kind.push_back(2);
            end else begin
               fail_run("unknown waveform kind in the trace file");
            end
            t_pace.push_back(p);
            t_level.push_back(lv);
            t_start.push_back(st);
            t_step.push_back(sp);
            t_rearm.push_back(re);
            t_chk.push_back(ck);
            t_min.push_back(mn);
            t_max.push_back(mx);
            t_avg.push_back(av);
         end
         $fclose(fd);
      end
   endtask

   // ticks through the level without an arm must leave everything quiet
   task automatic check_idle();
      int k;
      for (k = 0; k < 16; k++) begin
         adc_data  = sample_t'(k * 300);
         adc_valid = 1'b1;
         @(negedge clk);
         compare_flag("busy", 1'b0, busy);
         compare_flag("record_done", 1'b0, record_done);
         compare_flag("meas_valid", 1'b0, meas_valid);
         compare_sample("meas_min", '0, meas_min);
         compare_sample("meas_max", '0, meas_max);
         compare_sample("meas_average", '0, meas_average);
      end
      adc_valid = 1'b0;
   endtask

   task automatic run_case(input int c);
      int      eff_pace;
      int      n;
      int      rec_cnt;
      int      k;
      int      sum;
      bit      primed;
      bit      rearmed;
      sample_t s;
      sample_t prev;
      sample_t lvl;
      sample_t mn;
      sample_t mx;
      eff_pace      = (t_pace[c] == 0) ? 1 : t_pace[c];
      lvl           = sample_t'(t_level[c]);
      pace          = pace_count_t'(t_pace[c]);
      trigger_level = lvl;
      adc_valid     = 1'b0;
      repeat (2) @(negedge clk);
      arm = 1'b1;
      @(negedge clk);
      arm = 1'b0;
      compare_flag("busy", 1'b1, busy);
      n       = 0;
      rec_cnt = 0;
      primed  = 1'b0;
      rearmed = 1'b0;
      prev    = '0;
      while (rec_cnt < REC_LEN) begin
         if (t_kind[c] == 2) begin
            s = sample_t'($random(seed));
         end else begin
            s = wave_value(t_kind[c], t_start[c], t_step[c], n);
         end
         adc_data  = s;
         adc_valid = 1'b1;
         arm       = 1'b0;
         // second arm well inside the record
         if (t_rearm[c] != 0 && rec_cnt == 10 && !rearmed) begin
            arm     = 1'b1;
            rearmed = 1'b1;
         end
         // kept are the 1st, (pace+1)th, ... valid after arm
         if (n % eff_pace == 0) begin
            if (rec_cnt > 0) begin
               exp_rec[rec_cnt] = s;
               rec_cnt++;
            end else if (primed && prev < lvl && s >= lvl) begin
               exp_rec[0] = s;
               rec_cnt    = 1;
            end
            prev   = s;
            primed = 1'b1;
         end
         n++;
         @(negedge clk);
      end
      adc_valid = 1'b0;
      arm       = 1'b0;
      mn  = '1;
      mx  = '0;
      sum = 0;
      for (k = 0; k < REC_LEN; k++) begin
         if (exp_rec[k] < mn) begin
            mn = exp_rec[k];
         end
         if (exp_rec[k] > mx) begin
            mx = exp_rec[k];
         end
         sum += int'(exp_rec[k]);
      end
      k = 0;
      while (record_done !== 1'b1 && k < 64) begin
         // busy holds until the record is closed
         compare_flag("busy", 1'b1, busy);
         @(negedge clk);
         k++;
      end
      if (record_done !== 1'b1) begin
         fail_run("record_done never came after the last record sample");
      end else begin
         // busy drops together with record_done
         compare_flag("busy", 1'b0, busy);
         for (k = 1; k <= MERGE_LATENCY; k++) begin
            @(negedge clk);
            compare_flag("record_done", 1'b0, record_done);
            compare_flag("meas_valid", (k == MERGE_LATENCY), meas_valid);
         end
         if (t_chk[c] != 0) begin
            compare_sample("meas_min vs trace", sample_t'(t_min[c]), meas_min);
            compare_sample("meas_max vs trace", sample_t'(t_max[c]), meas_max);
            compare_sample("meas_average vs trace", sample_t'(t_avg[c]), meas_average);
         end
         compare_sample("meas_min", mn, meas_min);
         compare_sample("meas_max", mx, meas_max);
         compare_sample("meas_average", sample_t'(sum / REC_LEN), meas_average);
         @(negedge clk);
         compare_flag("meas_valid", 1'b0, meas_valid);
         // address 0 holds the crossing sample
         for (k = 0; k < REC_LEN; k++) begin
            rd_addr = record_addr_t'(k);
            @(negedge clk);
            compare_sample($sformatf("rd_data[%0d]", k), exp_rec[k], rd_data);
         end
      end
   endtask

   initial begin
      int c;
      int max_pace;
      rst           = 1'b1;
      adc_data      = '0;
      adc_valid     = 1'b0;
      pace          = pace_count_t'(1);
      trigger_level = sample_t'(12'h800);
      arm           = 1'b0;
      rd_addr       = '0;
      load_trace();
      if (t_pace.size() == 0) begin
         fail_run("the trace file holds no test cases");
      end else begin
         max_pace = 1;
         for (c = 0; c < t_pace.size(); c++) begin
            if (t_pace[c] > max_pace) begin
               max_pace = t_pace[c];
            end
         end
         cycle_limit = t_pace.size() * REC_LEN * max_pace * 4 + 1000;
         repeat (16) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         check_idle();
         for (c = 0; c < t_pace.size(); c++) begin
            run_case(c);
         end
         $display("TESTS PASSED");
         $finish;
      end
   end

   // stops a hung run
   initial begin
      wait (cycle_limit > 0);
      repeat (cycle_limit) @(posedge clk);
      fail_run($sformatf("watchdog expired after %0d cycles, the run did not finish", cycle_limit));
   end

endmodule
